// ==== common/ecdsa_pkg.sv ====
package ecdsa_pkg;

  // Stream and scalar geometry
  localparam int WORD_BITS = 64;
  localparam int SCALAR_BITS = 256;
  localparam int SCALAR_WORDS = SCALAR_BITS / WORD_BITS;

  // Header, index, s, r, z
  localparam int CMD_WORDS = 2 + 3 * SCALAR_WORDS;
  // Header, index, status, u1, u2
  localparam int RPL_WORDS = 3 + 2 * SCALAR_WORDS;

  // secp256k1 group order
  localparam logic [SCALAR_BITS-1:0] CURVE_N =
    256'hFFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFE_BAAEDCE6_AF48A03B_BFD25E8C_D0364141;

  // One extra bit for sums that can reach 2n
  localparam logic [SCALAR_BITS:0] CURVE_N_EXT = {1'b0, CURVE_N};

  typedef enum logic [15:0] {
    CMD_PREP_SCALARS = 16'h0010,
    RPL_PREP_SCALARS = 16'h0011
  } cmd_code_e;

  typedef struct packed {
    cmd_code_e   cmd;
    logic [15:0] reserved;
    logic [31:0] len;
  } cmd_header_t;

  typedef struct packed {
    logic [WORD_BITS-1:0] dat;
    logic                 sop;
    logic                 eop;
  } stream_beat_t;

  typedef logic [SCALAR_BITS-1:0] scalar_t;

  // Low byte of the reply status word
  typedef struct packed {
    logic       out_of_range_s;
    logic       out_of_range_r;
    logic [5:0] reserved;
  } sig_flags_t;

  typedef struct packed {
    logic [WORD_BITS-1:0] index;
    sig_flags_t           flags;
    scalar_t              s;
    scalar_t              r;
    scalar_t              z;
  } sig_job_t;

  typedef struct packed {
    logic [WORD_BITS-1:0] index;
    sig_flags_t           flags;
    scalar_t              w;
    scalar_t              r;
    scalar_t              z;
  } inv_job_t;

  typedef struct packed {
    logic [WORD_BITS-1:0] index;
    sig_flags_t           flags;
    scalar_t              u1;
    scalar_t              u2;
  } rpl_job_t;

endpackage

// ==== mod_arith/mod_mul_n.sv ====
`timescale 1ns/1ns

module mod_mul_n import ecdsa_pkg::*; (
  input           i_clk,
  input           i_rst,
  input           i_start,
  input  scalar_t i_a,
  input  scalar_t i_b,
  output logic    o_done,
  output scalar_t o_p
);

  scalar_t a_q, b_q, acc_q;
  scalar_t a_cur, b_cur, acc_cur;
  logic [SCALAR_BITS:0] dbl, dbl_r, sum, red;
  logic [$clog2(SCALAR_BITS)-1:0] cnt;
  logic busy;

  // First step runs on the start cycle itself
  always_comb begin
    a_cur = i_start ? ((i_a >= CURVE_N) ? (i_a - CURVE_N) : i_a) : a_q;
    b_cur = i_start ? i_b : b_q;
    acc_cur = i_start ? '0 : acc_q;
    dbl = {acc_cur, 1'b0};
    dbl_r = (dbl >= CURVE_N_EXT) ? (dbl - CURVE_N_EXT) : dbl;
    sum = dbl_r + (b_cur[SCALAR_BITS-1] ? {1'b0, a_cur} : '0);
    red = (sum >= CURVE_N_EXT) ? (sum - CURVE_N_EXT) : sum;
  end

  assign o_p = acc_q;

  always_ff @(posedge i_clk) begin
    if (i_start || busy) begin
      a_q <= a_cur;
      b_q <= b_cur << 1;
      acc_q <= red[SCALAR_BITS-1:0];
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      busy <= 1'b0;
      cnt <= '0;
      o_done <= 1'b0;
    end else begin
      o_done <= 1'b0;
      if (i_start) begin
        busy <= 1'b1;
        cnt <= $bits(cnt)'(SCALAR_BITS-1);
      end else if (busy) begin
        cnt <= cnt - 1'b1;
        if (cnt == 1) begin
          busy <= 1'b0;
          o_done <= 1'b1;
        end
      end
    end
  end

endmodule

// ==== mod_arith/mod_inv_n.sv ====
`timescale 1ns/1ns

module mod_inv_n import ecdsa_pkg::*; (
  input               i_clk,
  input               i_rst,
  input  sig_job_t    i_job,
  input               i_job_val,
  output logic        o_job_rdy,
  output inv_job_t    o_job,
  output logic        o_job_val,
  input               i_job_rdy
);

  typedef enum logic [1:0] {
    I_IDLE,
    I_RUN,
    I_DONE
  } inv_state_e;

  inv_state_e state;
  scalar_t u, v, x1, x2;

  // x / 2 mod n, n is odd
  function automatic scalar_t half_mod(input scalar_t x);
    logic [SCALAR_BITS:0] t;
    t = x[0] ? ({1'b0, x} + CURVE_N_EXT) : {1'b0, x};
    return t[SCALAR_BITS:1];
  endfunction

  // Wraps correctly since the true result lies in [0, n)
  function automatic scalar_t sub_mod(input scalar_t a, input scalar_t b);
    return (a >= b) ? (a - b) : (a - b + CURVE_N);
  endfunction

  assign o_job_rdy = (state == I_IDLE);
  assign o_job_val = (state == I_DONE);

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state <= I_IDLE;
    end else begin
      case (state)
        I_IDLE: begin
          if (i_job_val) begin
            o_job.index <= i_job.index;
            o_job.flags <= i_job.flags;
            o_job.r <= i_job.r;
            o_job.z <= i_job.z;
            if (i_job.flags != '0) begin
              o_job.w <= '0;
              state <= I_DONE;
            end else begin
              u <= i_job.s;
              v <= CURVE_N;
              x1 <= scalar_t'(1);
              x2 <= '0;
              state <= I_RUN;
            end
          end
        end
        I_RUN: begin
          if (u == scalar_t'(1)) begin
            o_job.w <= x1;
            state <= I_DONE;
          end else if (v == scalar_t'(1)) begin
            o_job.w <= x2;
            state <= I_DONE;
          end else if (!u[0]) begin
            u <= u >> 1;
            x1 <= half_mod(x1);
          end else if (!v[0]) begin
            v <= v >> 1;
            x2 <= half_mod(x2);
          end else if (u >= v) begin
            // Difference of two odd values is even, so halve it in the same step
            u <= (u - v) >> 1;
            x1 <= half_mod(sub_mod(x1, x2));
          end else begin
            v <= (v - u) >> 1;
            x2 <= half_mod(sub_mod(x2, x1));
          end
        end
        I_DONE: begin
          if (i_job_rdy) begin
            state <= I_IDLE;
          end
        end
        default: state <= I_IDLE;
      endcase
    end
  end

endmodule

// ==== verilog/cmd_parser.sv ====
`timescale 1ns/1ns

module cmd_parser import ecdsa_pkg::*; (
  input                i_clk,
  input                i_rst,
  input  stream_beat_t i_cmd,
  input                i_cmd_val,
  output logic         o_cmd_rdy,
  output sig_job_t     o_job,
  output logic         o_job_val,
  input                i_job_rdy
);

  typedef enum logic [1:0] {
    P_IDLE,
    P_INDEX,
    P_BODY,
    P_IGNORE
  } parse_state_e;

  parse_state_e state;
  logic [$clog2(3*SCALAR_WORDS)-1:0] cnt;
  cmd_header_t hdr;
  sig_flags_t chk_flags;
  logic accept;

  assign accept = i_cmd_val && o_cmd_rdy;
  assign hdr = i_cmd.dat;

  // s and r are complete by the time the z words arrive
  always_comb begin
    chk_flags = '0;
    chk_flags.out_of_range_s = (o_job.s == '0) || (o_job.s >= CURVE_N);
    chk_flags.out_of_range_r = (o_job.r == '0) || (o_job.r >= CURVE_N);
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state <= P_IDLE;
      cnt <= '0;
      o_cmd_rdy <= 1'b0;
      o_job_val <= 1'b0;
    end else begin
      if (o_job_val && i_job_rdy) begin
        o_job_val <= 1'b0;
      end
      if (!o_job_val || i_job_rdy) begin
        o_cmd_rdy <= 1'b1;
      end

      case (state)
        P_IDLE: begin
          if (accept) begin
            if (hdr.cmd == CMD_PREP_SCALARS) begin
              state <= P_INDEX;
            end else if (!i_cmd.eop) begin
              state <= P_IGNORE;
            end
          end
        end
        P_INDEX: begin
          if (accept) begin
            o_job.index <= i_cmd.dat;
            cnt <= '0;
            state <= P_BODY;
          end
        end
        P_BODY: begin
          if (accept) begin
            case (cnt[3:2])
              2'd0: o_job.s[cnt[1:0]*WORD_BITS +: WORD_BITS] <= i_cmd.dat;
              2'd1: o_job.r[cnt[1:0]*WORD_BITS +: WORD_BITS] <= i_cmd.dat;
              default: o_job.z[cnt[1:0]*WORD_BITS +: WORD_BITS] <= i_cmd.dat;
            endcase
            cnt <= cnt + 1'b1;
            if (cnt == 4'(3*SCALAR_WORDS-1)) begin
              // Hold the stream until the inverter takes this job
              o_job.flags <= chk_flags;
              o_job_val <= 1'b1;
              o_cmd_rdy <= 1'b0;
              state <= P_IDLE;
            end
          end
        end
        P_IGNORE: begin
          if (accept && i_cmd.eop) begin
            state <= P_IDLE;
          end
        end
        default: state <= P_IDLE;
      endcase
    end
  end

endmodule

// ==== verilog/u_calc.sv ====
`timescale 1ns/1ns

module u_calc import ecdsa_pkg::*; (
  input               i_clk,
  input               i_rst,
  input  inv_job_t    i_job,
  input               i_job_val,
  output logic        o_job_rdy,
  output rpl_job_t    o_job,
  output logic        o_job_val,
  input               i_job_rdy
);

  typedef enum logic [1:0] {
    U_IDLE,
    U_RUN,
    U_DONE
  } u_state_e;

  u_state_e state;
  inv_job_t job_q;
  logic mul_start;
  logic done_u1, done_u2;
  scalar_t p_u1, p_u2;

  assign o_job_rdy = (state == U_IDLE);
  assign o_job_val = (state == U_DONE);

  always_ff @(posedge i_clk) begin
    if (i_job_val && o_job_rdy) begin
      job_q <= i_job;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state <= U_IDLE;
      mul_start <= 1'b0;
    end else begin
      mul_start <= i_job_val && o_job_rdy;
      case (state)
        U_IDLE: begin
          if (i_job_val) begin
            state <= U_RUN;
          end
        end
        U_RUN: begin
          // Both multipliers start together and finish together
          if (done_u1 && done_u2) begin
            o_job.index <= job_q.index;
            o_job.flags <= job_q.flags;
            o_job.u1 <= p_u1;
            o_job.u2 <= p_u2;
            state <= U_DONE;
          end
        end
        U_DONE: begin
          if (i_job_rdy) begin
            state <= U_IDLE;
          end
        end
        default: state <= U_IDLE;
      endcase
    end
  end

  mod_mul_n mul_u1 (
    .i_clk   ( i_clk     ),
    .i_rst   ( i_rst     ),
    .i_start ( mul_start ),
    .i_a     ( job_q.z   ),
    .i_b     ( job_q.w   ),
    .o_done  ( done_u1   ),
    .o_p     ( p_u1      )
  );

  mod_mul_n mul_u2 (
    .i_clk   ( i_clk     ),
    .i_rst   ( i_rst     ),
    .i_start ( mul_start ),
    .i_a     ( job_q.r   ),
    .i_b     ( job_q.w   ),
    .o_done  ( done_u2   ),
    .o_p     ( p_u2      )
  );

endmodule

// ==== verilog/reply_packer.sv ====
`timescale 1ns/1ns

module reply_packer import ecdsa_pkg::*; (
  input                i_clk,
  input                i_rst,
  input  rpl_job_t     i_job,
  input                i_job_val,
  output logic         o_job_rdy,
  output stream_beat_t o_rpl,
  output logic         o_rpl_val,
  input                i_rpl_rdy
);

  rpl_job_t job_q;
  logic busy;
  logic [$clog2(RPL_WORDS)-1:0] beat;
  logic [$clog2(RPL_WORDS)-1:0] word_idx;
  cmd_header_t hdr;

  assign o_job_rdy = !busy;
  assign o_rpl_val = busy;

  always_comb begin
    hdr.cmd = RPL_PREP_SCALARS;
    hdr.reserved = '0;
    hdr.len = 32'(RPL_WORDS * 8);
  end

  // Scalar words start at beat 3, u1 first then u2
  assign word_idx = beat - 4'd3;

  always_comb begin
    o_rpl.sop = (beat == 0);
    o_rpl.eop = (beat == 4'(RPL_WORDS-1));
    case (beat)
      4'd0: o_rpl.dat = hdr;
      4'd1: o_rpl.dat = job_q.index;
      4'd2: o_rpl.dat = {{(WORD_BITS-8){1'b0}}, job_q.flags};
      default: begin
        if (beat < 4'(3 + SCALAR_WORDS)) begin
          o_rpl.dat = job_q.u1[word_idx[1:0]*WORD_BITS +: WORD_BITS];
        end else begin
          o_rpl.dat = job_q.u2[word_idx[1:0]*WORD_BITS +: WORD_BITS];
        end
      end
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_job_val && o_job_rdy) begin
      job_q <= i_job;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      busy <= 1'b0;
      beat <= '0;
    end else if (!busy) begin
      if (i_job_val) begin
        busy <= 1'b1;
        beat <= '0;
      end
    end else if (i_rpl_rdy) begin
      if (beat == 4'(RPL_WORDS-1)) begin
        busy <= 1'b0;
      end else begin
        beat <= beat + 1'b1;
      end
    end
  end

endmodule

// ==== verilog/ecdsa_prep_top.sv ====
`timescale 1ns/1ns

module ecdsa_prep_top import ecdsa_pkg::*; (
  input                i_clk,
  input                i_rst,
  input  stream_beat_t i_cmd,
  input                i_cmd_val,
  output logic         o_cmd_rdy,
  output stream_beat_t o_rpl,
  output logic         o_rpl_val,
  input                i_rpl_rdy
);

  sig_job_t sig_job;
  logic     sig_val, sig_rdy;
  inv_job_t inv_job;
  logic     inv_val, inv_rdy;
  rpl_job_t rpl_job;
  logic     rpl_val, rpl_rdy;

  cmd_parser cmd_parser (
    .i_clk     ( i_clk     ),
    .i_rst     ( i_rst     ),
    .i_cmd     ( i_cmd     ),
    .i_cmd_val ( i_cmd_val ),
    .o_cmd_rdy ( o_cmd_rdy ),
    .o_job     ( sig_job   ),
    .o_job_val ( sig_val   ),
    .i_job_rdy ( sig_rdy   )
  );

  // s inverse mod n
  mod_inv_n mod_inv_n (
    .i_clk     ( i_clk   ),
    .i_rst     ( i_rst   ),
    .i_job     ( sig_job ),
    .i_job_val ( sig_val ),
    .o_job_rdy ( sig_rdy ),
    .o_job     ( inv_job ),
    .o_job_val ( inv_val ),
    .i_job_rdy ( inv_rdy )
  );

  u_calc u_calc (
    .i_clk     ( i_clk   ),
    .i_rst     ( i_rst   ),
    .i_job     ( inv_job ),
    .i_job_val ( inv_val ),
    .o_job_rdy ( inv_rdy ),
    .o_job     ( rpl_job ),
    .o_job_val ( rpl_val ),
    .i_job_rdy ( rpl_rdy )
  );

  reply_packer reply_packer (
    .i_clk     ( i_clk     ),
    .i_rst     ( i_rst     ),
    .i_job     ( rpl_job   ),
    .i_job_val ( rpl_val   ),
    .o_job_rdy ( rpl_rdy   ),
    .o_rpl     ( o_rpl     ),
    .o_rpl_val ( o_rpl_val ),
    .i_rpl_rdy ( i_rpl_rdy )
  );

endmodule

// ==== verification/ecdsa_tb_util.svh ====
`ifndef ECDSA_TB_UTIL_SVH
`define ECDSA_TB_UTIL_SVH

// One row of the stimulus table
typedef struct {
  logic [15:0]          code;
  logic [WORD_BITS-1:0] index;
  scalar_t              s;
  scalar_t              r;
  scalar_t              z;
  sig_flags_t           flags;
} stim_entry_t;

// Full product, then one reduction mod n
function automatic scalar_t ref_mod_mul(input scalar_t a, input scalar_t b);
  logic [2*SCALAR_BITS-1:0] prod;
  prod = {256'b0, a} * {256'b0, b};
  return scalar_t'(prod % {256'b0, CURVE_N});
endfunction

// A scalar is usable only in the range 1 to n-1
function automatic sig_flags_t range_flags(input scalar_t s, input scalar_t r);
  sig_flags_t f;
  f = '0;
  f.out_of_range_s = (s == '0) || (s >= CURVE_N);
  f.out_of_range_r = (r == '0) || (r >= CURVE_N);
  return f;
endfunction

function automatic scalar_t rand_scalar();
  scalar_t v;
  for (int i = 0; i < SCALAR_BITS / 32; i++) begin
    v[i*32 +: 32] = $urandom;
  end
  return v;
endfunction

// Top bit cleared keeps the value below n
function automatic scalar_t rand_in_range();
  scalar_t v;
  v = rand_scalar();
  v[SCALAR_BITS-1] = 1'b0;
  if (v == '0) begin
    v = scalar_t'(1);
  end
  return v;
endfunction

// Drive one beat and hold it until the parser takes it
task automatic send_beat(input logic [WORD_BITS-1:0] dat, input logic sop, input logic eop);
  stream_beat_t b;
  b.dat = dat;
  b.sop = sop;
  b.eop = eop;
  i_cmd <= b;
  i_cmd_val <= 1'b1;
  @(posedge i_clk);
  while (!o_cmd_rdy) begin
    @(posedge i_clk);
  end
endtask

`endif

// ==== verification/ecdsa_prep_tb.sv ====
`timescale 1ns/1ns

module ecdsa_prep_tb import ecdsa_pkg::*; ();

  localparam int NUM_ENTRIES = 12;
  localparam logic [15:0] UNKNOWN_CODE = 16'h00A7;

  logic         i_clk = 1'b0;
  logic         i_rst;
  stream_beat_t i_cmd;
  logic         i_cmd_val;
  logic         o_cmd_rdy;
  stream_beat_t o_rpl;
  logic         o_rpl_val;
  logic         i_rpl_rdy;

  `include "ecdsa_tb_util.svh"

  stim_entry_t          stim_table [NUM_ENTRIES];
  int                   expect_q [$];
  int                   expected_total;
  int                   replies_seen;
  int                   beat_cnt;
  logic [WORD_BITS-1:0] rpl_words [RPL_WORDS];
  logic                 stalled;
  stream_beat_t         held_beat;

  ecdsa_prep_top i_ecdsa_prep_top (
    .i_clk     ( i_clk     ),
    .i_rst     ( i_rst     ),
    .i_cmd     ( i_cmd     ),
    .i_cmd_val ( i_cmd_val ),
    .o_cmd_rdy ( o_cmd_rdy ),
    .o_rpl     ( o_rpl     ),
    .o_rpl_val ( o_rpl_val ),
    .i_rpl_rdy ( i_rpl_rdy )
  );

  always #10 i_clk = ~i_clk;

  task automatic abort_run();
    $display("test failed");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic report_mismatch(input string sig, input logic [255:0] exp,
                                 input logic [255:0] act);
    $display("Error at %0t ns: %s expected %h, got %h", $time, sig, exp, act);
    abort_run();
  endtask

  task automatic report_failure(input string what);
    $display("Failure at %0t ns: %s", $time, what);
    abort_run();
  endtask

  function automatic stim_entry_t make_entry(input logic [15:0] code, input scalar_t s,
                                             input scalar_t r);
    stim_entry_t e;
    e.code = code;
    e.index = {$urandom, $urandom};
    e.s = s;
    e.r = r;
    e.z = rand_scalar();
    e.flags = range_flags(s, r);
    return e;
  endfunction

  // Unknown commands carry header, index, three s words and one z word
  task automatic send_command(input stim_entry_t e);
    logic [31:0] len;
    len = (e.code == CMD_PREP_SCALARS) ? 32'(CMD_WORDS * 8) : 32'd48;
    send_beat({e.code, 16'h0000, len}, 1'b1, 1'b0);
    send_beat(e.index, 1'b0, 1'b0);
    if (e.code == CMD_PREP_SCALARS) begin
      for (int i = 0; i < SCALAR_WORDS; i++) begin
        send_beat(e.s[i*WORD_BITS +: WORD_BITS], 1'b0, 1'b0);
      end
      for (int i = 0; i < SCALAR_WORDS; i++) begin
        send_beat(e.r[i*WORD_BITS +: WORD_BITS], 1'b0, 1'b0);
      end
      for (int i = 0; i < SCALAR_WORDS; i++) begin
        send_beat(e.z[i*WORD_BITS +: WORD_BITS], 1'b0, i == SCALAR_WORDS - 1);
      end
    end else begin
      for (int i = 0; i < 3; i++) begin
        send_beat(e.s[i*WORD_BITS +: WORD_BITS], 1'b0, 1'b0);
      end
      send_beat(e.z[WORD_BITS-1:0], 1'b0, 1'b1);
    end
  endtask

  task automatic check_reply();
    int          idx;
    stim_entry_t e;
    cmd_header_t hdr;
    scalar_t     u1;
    scalar_t     u2;
    assert (expect_q.size() > 0)
      else report_failure("reply arrived with no command outstanding");
    idx = expect_q.pop_front();
    e = stim_table[idx];
    hdr = rpl_words[0];
    for (int i = 0; i < SCALAR_WORDS; i++) begin
      u1[i*WORD_BITS +: WORD_BITS] = rpl_words[3+i];
      u2[i*WORD_BITS +: WORD_BITS] = rpl_words[3+SCALAR_WORDS+i];
    end
    assert (hdr.cmd == RPL_PREP_SCALARS)
      else report_mismatch("header cmd", 256'(RPL_PREP_SCALARS), 256'(hdr.cmd));
    assert (hdr.reserved == 16'h0)
      else report_mismatch("header reserved", 256'(0), 256'(hdr.reserved));
    assert (hdr.len == 32'd88) else report_mismatch("header len", 256'(88), 256'(hdr.len));
    assert (rpl_words[1] == e.index)
      else report_mismatch("reply index", 256'(e.index), 256'(rpl_words[1]));
    assert (rpl_words[2] == {56'b0, e.flags})
      else report_mismatch("status word", 256'({56'b0, e.flags}), 256'(rpl_words[2]));
    if (e.flags == '0) begin
      assert (u1 < CURVE_N) else report_mismatch("u1 range", CURVE_N, u1);
      assert (u2 < CURVE_N) else report_mismatch("u2 range", CURVE_N, u2);
      assert (ref_mod_mul(u1, e.s) == e.z % CURVE_N)
        else report_mismatch("u1*s mod n", e.z % CURVE_N, ref_mod_mul(u1, e.s));
      assert (ref_mod_mul(u2, e.s) == e.r)
        else report_mismatch("u2*s mod n", e.r, ref_mod_mul(u2, e.s));
    end else begin
      assert (u1 == '0) else report_mismatch("u1", 256'(0), u1);
      assert (u2 == '0) else report_mismatch("u2", 256'(0), u2);
    end
    replies_seen++;
  endtask

  // Random back-pressure on the reply stream
  initial begin : rpl_backpressure
    i_rpl_rdy = 1'b0;
    forever begin
      @(posedge i_clk);
      if (i_rst) begin
        i_rpl_rdy <= 1'b0;
      end else begin
        i_rpl_rdy <= ($urandom_range(99) < 70);
      end
    end
  end

  // Reply monitor takes beats where valid and ready meet at the edge
  always @(posedge i_clk) begin
    if (i_rst) begin
      stalled = 1'b0;
      beat_cnt = 0;
    end else begin
      if (stalled) begin
        assert (o_rpl_val) else report_failure("o_rpl_val dropped during a stall");
        assert (o_rpl == held_beat)
          else report_mismatch("o_rpl", 256'(held_beat), 256'(o_rpl));
      end
      if (o_rpl_val && i_rpl_rdy) begin
        assert (o_rpl.sop == (beat_cnt == 0))
          else report_mismatch("o_rpl.sop", 256'(beat_cnt == 0), 256'(o_rpl.sop));
        assert (o_rpl.eop == (beat_cnt == RPL_WORDS - 1))
          else report_mismatch("o_rpl.eop", 256'(beat_cnt == RPL_WORDS - 1), 256'(o_rpl.eop));
        rpl_words[beat_cnt] = o_rpl.dat;
        if (beat_cnt == RPL_WORDS - 1) begin
          check_reply();
          beat_cnt = 0;
        end else begin
          beat_cnt++;
        end
      end
      stalled = o_rpl_val && !i_rpl_rdy;
      held_beat = o_rpl;
    end
  end

  initial begin : watchdog
    repeat (NUM_ENTRIES * 4000) @(posedge i_clk);
    report_failure("timed out waiting for replies");
  end

  initial begin : stimulus
    void'($urandom(87044));
    i_rst = 1'b1;
    i_cmd = '0;
    i_cmd_val = 1'b0;
    replies_seen = 0;
    expected_total = 0;

    stim_table[0] = make_entry(CMD_PREP_SCALARS, rand_in_range(), rand_in_range());
    stim_table[1] = make_entry(CMD_PREP_SCALARS, '0, rand_in_range());
    stim_table[2] = make_entry(CMD_PREP_SCALARS, CURVE_N, rand_in_range());
    stim_table[3] = make_entry(CMD_PREP_SCALARS, rand_in_range(), rand_in_range());
    stim_table[4] = make_entry(CMD_PREP_SCALARS, rand_in_range(), '0);
    stim_table[5] = make_entry(CMD_PREP_SCALARS, rand_in_range(), '1);
    stim_table[6] = make_entry(UNKNOWN_CODE, rand_in_range(), rand_in_range());
    stim_table[7] = make_entry(CMD_PREP_SCALARS, scalar_t'(1), CURVE_N - 1);
    stim_table[8] = make_entry(CMD_PREP_SCALARS, CURVE_N - 1, scalar_t'(1));
    for (int i = 9; i < NUM_ENTRIES; i++) begin
      stim_table[i] = make_entry(CMD_PREP_SCALARS, rand_in_range(), rand_in_range());
    end

    repeat (5) @(posedge i_clk);
    // Both sides of the DUT stay closed while reset is held
    assert (!o_cmd_rdy && !o_rpl_val)
      else report_failure("o_cmd_rdy or o_rpl_val high during reset");
    i_rst <= 1'b0;

    // Commands go out back to back and the parser's ready paces them
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      if (stim_table[i].code == CMD_PREP_SCALARS) begin
        expect_q.push_back(i);
        expected_total++;
      end
      send_command(stim_table[i]);
    end
    i_cmd_val <= 1'b0;

    wait (replies_seen == expected_total);
    // A stray reply in this window finds the expected queue empty
    repeat (1000) @(posedge i_clk);
    $display("test passed");
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+verification
common/ecdsa_pkg.sv
mod_arith/mod_mul_n.sv
mod_arith/mod_inv_n.sv
verilog/cmd_parser.sv
verilog/u_calc.sv
verilog/reply_packer.sv
verilog/ecdsa_prep_top.sv
verification/ecdsa_prep_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the ECDSA prep testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module ecdsa_prep_tb \
  -f files.f -o ecdsa_prep_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/ecdsa_prep_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^test passed$" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1
